//--- flist.f
+incdir+.
hpdcache_ctrl_req_pkg.sv
hpdcache_ctrl_status_pkg.sv
hpdcache_ctrl_replay_sel.sv
hpdcache_ctrl_st1_dec.sv
hpdcache_ctrl_st0_admit.sv
hpdcache_ctrl_pe.sv
hpdcache_ctrl_properties.sv
hpdcache_ctrl_tb.sv

//--- hpdcache_ctrl_pe.sv
// Purely combinational, no clock or reset; all outputs settle in the same cycle
`timescale 1ns/1ns

module hpdcache_ctrl_pe (
    // Request and refill arbiter
    input  wire logic                                  arb_st0_req_valid_i,
    output var  logic                                  arb_st0_req_ready_o,
    input  wire logic                                  arb_refill_valid_i,
    output var  logic                                  arb_refill_ready_o,
    // Stage 0
    input  wire hpdcache_ctrl_req_pkg::req_flags_t     st0_req_i,
    output var  logic                                  st0_req_mshr_check_o,
    output var  logic                                  st0_req_cachedir_read_o,
    output var  logic                                  st0_req_cachedata_read_o,
    // Stage 1
    input  wire hpdcache_ctrl_req_pkg::st1_req_t       st1_req_i,
    output var  logic                                  st1_req_valid_o,
    output var  hpdcache_ctrl_status_pkg::st1_action_t st1_action_o,
    output var  hpdcache_ctrl_status_pkg::rtab_cause_t st1_cause_o,
    // Stage 2
    input  wire logic                                  st2_req_valid_i,
    output var  logic                                  st2_req_valid_o,
    output var  logic                                  st2_mshr_alloc_o,
    // Replay table
    input  wire logic                                  rtab_full_i,
    input  wire logic                                  rtab_req_valid_i,
    output var  logic                                  rtab_sel_o,
    output var  logic                                  rtab_check_o,
    input  wire logic                                  rtab_check_hit_i,
    output var  logic                                  st0_rtab_alloc_o,
    // Resource status and hold conditions
    input  wire hpdcache_ctrl_status_pkg::rsrc_status_t status_i,
    input  wire logic                                  cachedir_init_ready_i,
    input  wire logic                                  refill_busy_i,
    input  wire logic                                  cmo_busy_i,
    input  wire logic                                  uc_busy_i
);
    logic pipe_active;
    logic bubble;
    logic st0_fence;

    hpdcache_ctrl_replay_sel u_replay_sel (
        .st0_req_i        (st0_req_i),
        .st1_req_i        (st1_req_i),
        .rtab_full_i      (rtab_full_i),
        .rtab_req_valid_i (rtab_req_valid_i),
        .cmo_busy_i       (cmo_busy_i),
        .uc_busy_i        (uc_busy_i),
        .rtab_sel_o       (rtab_sel_o),
        .st0_fence_o      (st0_fence)
    );

    hpdcache_ctrl_st1_dec u_st1_dec (
        .st1_req_i             (st1_req_i),
        .st2_req_valid_i       (st2_req_valid_i),
        .status_i              (status_i),
        .cachedir_init_ready_i (cachedir_init_ready_i),
        .refill_busy_i         (refill_busy_i),
        .rtab_sel_i            (rtab_sel_o),
        .arb_st0_req_valid_i   (arb_st0_req_valid_i),
        .st0_req_i             (st0_req_i),
        .pipe_active_o         (pipe_active),
        .action_o              (st1_action_o),
        .cause_o               (st1_cause_o),
        .st2_req_valid_o       (st2_req_valid_o),
        .st2_mshr_alloc_o      (st2_mshr_alloc_o),
        .bubble_o              (bubble)
    );

    hpdcache_ctrl_st0_admit u_st0_admit (
        .pipe_active_i            (pipe_active),
        .bubble_i                 (bubble),
        .arb_st0_req_valid_i      (arb_st0_req_valid_i),
        .arb_refill_valid_i       (arb_refill_valid_i),
        .st0_req_i                (st0_req_i),
        .st0_fence_i              (st0_fence),
        .st1_req_i                (st1_req_i),
        .st2_req_valid_i          (st2_req_valid_i),
        .rtab_sel_i               (rtab_sel_o),
        .rtab_check_hit_i         (rtab_check_hit_i),
        .arb_st0_req_ready_o      (arb_st0_req_ready_o),
        .arb_refill_ready_o       (arb_refill_ready_o),
        .rtab_check_o             (rtab_check_o),
        .st0_rtab_alloc_o         (st0_rtab_alloc_o),
        .st1_req_valid_o          (st1_req_valid_o),
        .st0_req_mshr_check_o     (st0_req_mshr_check_o),
        .st0_req_cachedir_read_o  (st0_req_cachedir_read_o),
        .st0_req_cachedata_read_o (st0_req_cachedata_read_o)
    );

endmodule

//--- hpdcache_ctrl_properties.sv
// Sampled on an external clock, inputs must be stable at the rising edge; idle while rst_i is high
`timescale 1ns/1ns

module hpdcache_ctrl_properties (
    input wire logic                                  clk_i,
    input wire logic                                  rst_i,
    input wire hpdcache_ctrl_req_pkg::st1_req_t       st1_req_i,
    input wire hpdcache_ctrl_status_pkg::st1_action_t st1_action_i,
    input wire hpdcache_ctrl_status_pkg::rtab_cause_t st1_cause_i,
    input wire logic                                  arb_st0_req_ready_i,
    input wire logic                                  arb_refill_ready_i
);
    int violation_count = 0;

    // A stage 1 request is parked or retired, never both in one cycle
    a_no_park_with_commit : assert property (@(posedge clk_i) disable iff (rst_i)
        !((st1_action_i.rtab_alloc | st1_action_i.rtab_rback) & st1_action_i.rtab_commit))
    else begin
        $error("replay alloc or rollback high together with commit");
        violation_count++;
    end

    // Causes follow a priority, so only one can be named
    a_single_cause : assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(hpdcache_ctrl_status_pkg::rtab_cause_vec_t'(st1_cause_i)))
    else begin
        $error("more than one replay cause set");
        violation_count++;
    end

    // Refill needs an empty pipeline
    a_refill_core_exclusive : assert property (@(posedge clk_i) disable iff (rst_i)
        st1_req_i.valid |-> !(arb_refill_ready_i && arb_st0_req_ready_i))
    else begin
        $error("refill and core request both granted with stage 1 valid");
        violation_count++;
    end

endmodule

//--- hpdcache_ctrl_replay_sel.sv
// Combinational only; busy flags from the CMO and uncached handlers must be level signals
`timescale 1ns/1ns

module hpdcache_ctrl_replay_sel (
    input  wire hpdcache_ctrl_req_pkg::req_flags_t st0_req_i,
    input  wire hpdcache_ctrl_req_pkg::st1_req_t   st1_req_i,
    input  wire logic                              rtab_full_i,
    input  wire logic                              rtab_req_valid_i,
    input  wire logic                              cmo_busy_i,
    input  wire logic                              uc_busy_i,
    output var  logic                              rtab_sel_o,
    output var  logic                              st0_fence_o
);
    logic st1_fence;

    // A fence must run in program order with respect to every other access
    assign st0_fence_o = st0_req_i.uncacheable  |
                         st0_req_i.is_cmo_fence |
                         st0_req_i.is_cmo_inval |
                         st0_req_i.is_amo;

    assign st1_fence = st1_req_i.flags.uncacheable  |
                       st1_req_i.flags.is_cmo_fence |
                       st1_req_i.flags.is_cmo_inval |
                       st1_req_i.flags.is_amo;

    // Stage 0 slot goes to the replay table when
    // the table is full, so a new core request cannot deadlock on it,
    // a parked request has its dependencies solved,
    // or a fence is in flight or still held by a handler
    assign rtab_sel_o = rtab_full_i                  |
                        rtab_req_valid_i             |
                        (st1_req_i.valid & st1_fence) |
                        cmo_busy_i                   |
                        uc_busy_i;

endmodule

//--- hpdcache_ctrl_req_pkg.sv
// Flag order is fixed; a kind vector casts directly onto req_flags_t
`include "hpdcache_ctrl_settings.svh"

package hpdcache_ctrl_req_pkg;

    // Request kind flags as a plain vector, MSB is uncacheable
    typedef logic [`HPDC_CTRL_REQ_FLAGS_W-1:0] req_kind_vec_t;

    // Kind of a request in stage 0 or stage 1
    typedef struct packed {
        logic uncacheable;
        logic need_rsp;
        logic is_load;
        logic is_store;
        logic is_amo;
        logic is_cmo_fence;
        logic is_cmo_inval;
    } req_flags_t;

    // Stage 1 request, as seen by the control engine
    typedef struct packed {
        logic       valid;
        // Request was issued from the replay table
        logic       rtab;
        req_flags_t flags;
    } st1_req_t;

endpackage

//--- hpdcache_ctrl_settings.svh
// Field counts are fixed by the cache protocol and must match the packed flag structs
`ifndef HPDCACHE_CTRL_SETTINGS_SVH
`define HPDCACHE_CTRL_SETTINGS_SVH

// Request kind flags
// uncacheable, need_rsp, load, store, amo, cmo fence, cmo inval
`define HPDC_CTRL_REQ_FLAGS_W 7

// Replay table causes
// mshr hit, mshr full, mshr not ready, wbuf hit, wbuf not ready
`define HPDC_CTRL_CAUSE_W 5

`endif

//--- hpdcache_ctrl_st0_admit.sv
// Combinational only; ready is a plain level and the caller keeps its valid high
`timescale 1ns/1ns

module hpdcache_ctrl_st0_admit (
    input  wire logic                              pipe_active_i,
    input  wire logic                              bubble_i,
    input  wire logic                              arb_st0_req_valid_i,
    input  wire logic                              arb_refill_valid_i,
    input  wire hpdcache_ctrl_req_pkg::req_flags_t st0_req_i,
    input  wire logic                              st0_fence_i,
    input  wire hpdcache_ctrl_req_pkg::st1_req_t   st1_req_i,
    input  wire logic                              st2_req_valid_i,
    input  wire logic                              rtab_sel_i,
    input  wire logic                              rtab_check_hit_i,
    output var  logic                              arb_st0_req_ready_o,
    output var  logic                              arb_refill_ready_o,
    output var  logic                              rtab_check_o,
    output var  logic                              st0_rtab_alloc_o,
    output var  logic                              st1_req_valid_o,
    output var  logic                              st0_req_mshr_check_o,
    output var  logic                              st0_req_cachedir_read_o,
    output var  logic                              st0_req_cachedata_read_o
);
    logic st0_cacheable;
    logic st1_cacheable_store;

    // Core request is taken unless a bubble is pending
    assign arb_st0_req_ready_o = pipe_active_i & arb_st0_req_valid_i & ~bubble_i;

    // Refill only into an empty pipeline
    assign arb_refill_ready_o = pipe_active_i & arb_refill_valid_i &
                                ~(st1_req_i.valid | st2_req_valid_i);

    // Non-fence core requests are checked against parked requests
    assign rtab_check_o     = arb_st0_req_ready_o & ~rtab_sel_i & ~st0_fence_i;
    assign st0_rtab_alloc_o = rtab_check_o & rtab_check_hit_i;

    // Forward to stage 1 unless parked on a conflict
    // Stage 1 valid passes through while the pipeline holds
    assign st1_req_valid_o = pipe_active_i ?
                             arb_st0_req_ready_o & (rtab_sel_i | st0_fence_i | ~rtab_check_hit_i) :
                             st1_req_i.valid;

    // RAMs are enabled even if the request gets parked later
    assign st0_cacheable       = pipe_active_i & arb_st0_req_valid_i & ~st0_req_i.uncacheable;
    assign st1_cacheable_store = st1_req_i.valid & st1_req_i.flags.is_store &
                                 ~st1_req_i.flags.uncacheable;

    assign st0_req_mshr_check_o    = st0_cacheable &
                                     (st0_req_i.is_load | st0_req_i.is_store | st0_req_i.is_amo);
    // AMO never reads the directory
    assign st0_req_cachedir_read_o = st0_cacheable & ~st0_req_i.is_amo &
                                     (st0_req_i.is_load | st0_req_i.is_store);
    // Data RAM port is taken by a stage 1 store
    assign st0_req_cachedata_read_o = st0_cacheable & st0_req_i.is_load & ~st1_cacheable_store;

endmodule

//--- hpdcache_ctrl_st1_dec.sv
// Combinational only; one request kind is served per cycle, AMO before load before store
`timescale 1ns/1ns

module hpdcache_ctrl_st1_dec (
    input  wire hpdcache_ctrl_req_pkg::st1_req_t       st1_req_i,
    input  wire logic                                  st2_req_valid_i,
    input  wire hpdcache_ctrl_status_pkg::rsrc_status_t status_i,
    input  wire logic                                  cachedir_init_ready_i,
    input  wire logic                                  refill_busy_i,
    input  wire logic                                  rtab_sel_i,
    input  wire logic                                  arb_st0_req_valid_i,
    input  wire hpdcache_ctrl_req_pkg::req_flags_t     st0_req_i,
    output var  logic                                  pipe_active_o,
    output var  hpdcache_ctrl_status_pkg::st1_action_t action_o,
    output var  hpdcache_ctrl_status_pkg::rtab_cause_t cause_o,
    output var  logic                                  st2_req_valid_o,
    output var  logic                                  st2_mshr_alloc_o,
    output var  logic                                  bubble_o
);
    logic st1_alloc;
    logic st1_nop;
    logic st2_nop;

    // Pipeline holds while the RAMs initialise or the miss handler owns the cache
    assign pipe_active_o = cachedir_init_ready_i & ~refill_busy_i;

    always_comb begin
        action_o         = '0;
        cause_o          = '0;
        st1_alloc        = 1'b0;
        st1_nop          = 1'b0;
        st2_nop          = 1'b0;
        st2_mshr_alloc_o = 1'b0;

        if (pipe_active_o) begin
            // Stage 2 holds a miss, allocate its MSHR entry
            // Bubble next cycle avoids an MSHR read-after-allocate hazard
            if (st2_req_valid_i) begin
                st2_mshr_alloc_o = 1'b1;
                st2_nop          = 1'b1;
            end

            if (st1_req_i.valid) begin
                // CMO fence or invalidate goes to the CMO handler
                if (st1_req_i.flags.is_cmo_fence || st1_req_i.flags.is_cmo_inval) begin
                    action_o.cmo_req_valid = 1'b1;
                    st1_nop                = 1'b1;
                end
                // Uncached accesses and all AMOs go to the uncached handler
                else if (st1_req_i.flags.uncacheable || st1_req_i.flags.is_amo) begin
                    action_o.uc_req_valid = 1'b1;
                    st1_nop               = 1'b1;
                end
                else if (st1_req_i.flags.is_load) begin
                    if (!status_i.cachedir_hit) begin
                        // Close a matching open write buffer entry right away
                        action_o.wbuf_read_close_hit = 1'b1;
                        st1_nop                      = 1'b1;
                        // Replay causes in priority order
                        if (status_i.mshr_hit) begin
                            st1_alloc        = 1'b1;
                            cause_o.mshr_hit = 1'b1;
                        end else if (status_i.mshr_full) begin
                            st1_alloc         = 1'b1;
                            cause_o.mshr_full = 1'b1;
                        end else if (status_i.wbuf_read_hit) begin
                            st1_alloc        = 1'b1;
                            cause_o.wbuf_hit = 1'b1;
                        end else if (!status_i.mshr_alloc_ready) begin
                            // Miss handler busy, park so refill responses can drain
                            st1_alloc          = 1'b1;
                            cause_o.mshr_ready = 1'b1;
                        end else begin
                            // Forward to stage 2 for MSHR allocation and refill
                            action_o.rtab_commit = st1_req_i.rtab;
                            action_o.st2_valid   = 1'b1;
                            action_o.st2_we      = 1'b1;
                        end
                    end else begin
                        action_o.rtab_commit       = st1_req_i.rtab;
                        // Replayed hit blocks the core slot unless replay keeps it
                        st1_nop                    = st1_req_i.rtab & ~rtab_sel_i;
                        action_o.cachedir_updt_lru = 1'b1;
                        action_o.rsp_valid         = st1_req_i.flags.need_rsp;
                    end
                end
                else if (st1_req_i.flags.is_store) begin
                    // Hold the write while a read miss to the same line is pending
                    action_o.wbuf_write_valid = ~status_i.mshr_hit;
                    // Data RAM conflict with a cacheable load in stage 0
                    st1_nop = (arb_st0_req_valid_i & st0_req_i.is_load & ~st0_req_i.uncacheable) |
                              (st1_req_i.rtab & ~rtab_sel_i);
                    // RAM enabled early, actual write needs the hit below
                    action_o.cachedata_write = 1'b1;

                    if (!status_i.cachedir_hit && status_i.mshr_hit) begin
                        st1_alloc        = 1'b1;
                        cause_o.mshr_hit = 1'b1;
                        st1_nop          = 1'b1;
                    end else if (!status_i.wbuf_write_ready) begin
                        st1_alloc              = 1'b1;
                        cause_o.wbuf_not_ready = 1'b1;
                        st1_nop                = 1'b1;
                    end else begin
                        action_o.rtab_commit = st1_req_i.rtab;
                        action_o.rsp_valid   = st1_req_i.flags.need_rsp;
                        // Only a hit updates the LRU and writes the data RAM
                        action_o.cachedir_updt_lru      = status_i.cachedir_hit;
                        action_o.cachedata_write_enable = status_i.cachedir_hit;
                    end
                end
            end

            // New park or put back a replayed request
            action_o.rtab_alloc = st1_alloc & ~st1_req_i.rtab;
            action_o.rtab_rback = st1_alloc &  st1_req_i.rtab;
        end
    end

    // Stage 2 valid passes through while the pipeline holds
    assign st2_req_valid_o = pipe_active_o ? action_o.st2_valid : st2_req_valid_i;
    assign bubble_o        = st1_nop | st2_nop;

endmodule

//--- hpdcache_ctrl_status_pkg.sv
// Status inputs are sampled in stage 1; at most one replay cause is set per cycle
`include "hpdcache_ctrl_settings.svh"

package hpdcache_ctrl_status_pkg;

    // Directory, MSHR and write buffer status for the stage 1 request
    typedef struct packed {
        logic cachedir_hit;
        logic mshr_hit;
        logic mshr_full;
        logic mshr_alloc_ready;
        logic wbuf_write_ready;
        logic wbuf_read_hit;
    } rsrc_status_t;

    // One bit per replay cause, same order as rtab_cause_t
    typedef logic [`HPDC_CTRL_CAUSE_W-1:0] rtab_cause_vec_t;

    typedef struct packed {
        logic mshr_hit;
        logic mshr_full;
        logic mshr_ready;
        logic wbuf_hit;
        logic wbuf_not_ready;
    } rtab_cause_t;

    // Everything decided for the stage 1 request in one cycle
    typedef struct packed {
        logic rsp_valid;
        logic cachedir_updt_lru;
        logic cachedata_write;
        logic cachedata_write_enable;
        logic wbuf_write_valid;
        logic wbuf_read_close_hit;
        logic uc_req_valid;
        logic cmo_req_valid;
        logic rtab_alloc;
        logic rtab_rback;
        logic rtab_commit;
        // Stage 1 request moves on to stage 2
        logic st2_valid;
        logic st2_we;
    } st1_action_t;

endpackage

//--- hpdcache_ctrl_tb.sv
// Fixed LFSR seed; inputs change on the falling edge, outputs are compared at the rising edge
`timescale 1ns/1ns

module hpdcache_ctrl_tb;
    typedef hpdcache_ctrl_req_pkg::req_kind_vec_t   req_kind_vec_t;
    typedef hpdcache_ctrl_req_pkg::req_flags_t      req_flags_t;
    typedef hpdcache_ctrl_req_pkg::st1_req_t        st1_req_t;
    typedef hpdcache_ctrl_status_pkg::rsrc_status_t rsrc_status_t;
    typedef hpdcache_ctrl_status_pkg::rtab_cause_t  rtab_cause_t;
    typedef hpdcache_ctrl_status_pkg::st1_action_t  st1_action_t;

    localparam int          NUM_CYCLES     = 2000;
    localparam int          RESET_CYCLES   = 5;
    // Reset, the random cycles and some slack
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 95;
    localparam logic [15:0] LFSR_SEED      = 16'd30373;

    logic        clk_i       = 1'b0;
    logic        rst_i       = 1'b1;
    logic [15:0] lfsr_state  = LFSR_SEED;
    int          cycle_count = 0;

    // DUT inputs, all idle at time zero
    logic         arb_st0_req_valid_i   = 1'b0;
    logic         arb_refill_valid_i    = 1'b0;
    req_flags_t   st0_req_i             = '0;
    st1_req_t     st1_req_i             = '0;
    logic         st2_req_valid_i       = 1'b0;
    logic         rtab_full_i           = 1'b0;
    logic         rtab_req_valid_i      = 1'b0;
    logic         rtab_check_hit_i      = 1'b0;
    rsrc_status_t status_i              = '0;
    logic         cachedir_init_ready_i = 1'b0;
    logic         refill_busy_i         = 1'b0;
    logic         cmo_busy_i            = 1'b0;
    logic         uc_busy_i             = 1'b0;

    // DUT outputs
    logic        arb_st0_req_ready_o;
    logic        arb_refill_ready_o;
    logic        st0_req_mshr_check_o;
    logic        st0_req_cachedir_read_o;
    logic        st0_req_cachedata_read_o;
    logic        st1_req_valid_o;
    st1_action_t st1_action_o;
    rtab_cause_t st1_cause_o;
    logic        st2_req_valid_o;
    logic        st2_mshr_alloc_o;
    logic        rtab_sel_o;
    logic        rtab_check_o;
    logic        st0_rtab_alloc_o;

    // Reference model results
    st1_action_t exp_action;
    rtab_cause_t exp_cause;
    logic        exp_core_ready;
    logic        exp_refill_ready;
    logic        exp_rtab_sel;
    logic        exp_rtab_check;
    logic        exp_st0_rtab_alloc;
    logic        exp_st1_valid;
    logic        exp_st2_valid;
    logic        exp_st2_alloc;
    logic        exp_mshr_check;
    logic        exp_dir_read;
    logic        exp_data_read;

    hpdcache_ctrl_pe DUT (.*);

    bind hpdcache_ctrl_pe hpdcache_ctrl_properties u_properties (
        .clk_i               (hpdcache_ctrl_tb.clk_i),
        .rst_i               (hpdcache_ctrl_tb.rst_i),
        .st1_req_i           (st1_req_i),
        .st1_action_i        (st1_action_o),
        .st1_cause_i         (st1_cause_o),
        .arb_st0_req_ready_i (arb_st0_req_ready_o),
        .arb_refill_ready_i  (arb_refill_ready_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            stop_on_failure("timeout");
        end
    end

    task automatic stop_on_failure(input string reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped: %s", reason);
    endtask

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic next_random_bit();
        lfsr_state = {lfsr_state[14:0],
                      lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
        return lfsr_state[0];
    endfunction

    function automatic logic [31:0] draw_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    function automatic logic one_in_four();
        return draw_bits(2) == 32'd0;
    endfunction

    function automatic req_flags_t draw_flags();
        logic [31:0]   raw;
        req_kind_vec_t kind;
        req_flags_t    flags;
        raw   = draw_bits($bits(req_kind_vec_t));
        kind  = raw[$bits(req_kind_vec_t)-1:0];
        flags = req_flags_t'(kind);
        // Mostly plain cacheable accesses so load and store paths get exercised
        if (draw_bits(2) != 32'd0) begin
            flags.uncacheable  = 1'b0;
            flags.is_amo       = 1'b0;
            flags.is_cmo_fence = 1'b0;
            flags.is_cmo_inval = 1'b0;
        end
        return flags;
    endfunction

    function automatic logic is_fence(input req_flags_t f);
        return f.uncacheable | f.is_cmo_fence | f.is_cmo_inval | f.is_amo;
    endfunction

    task automatic drive_random_inputs;
        logic [31:0] raw;
        arb_st0_req_valid_i = next_random_bit();
        arb_refill_valid_i  = next_random_bit();
        st0_req_i           = draw_flags();
        st1_req_i.valid     = next_random_bit();
        st1_req_i.rtab      = next_random_bit();
        st1_req_i.flags     = draw_flags();
        st2_req_valid_i     = next_random_bit();
        raw                 = draw_bits($bits(rsrc_status_t));
        status_i            = rsrc_status_t'(raw[$bits(rsrc_status_t)-1:0]);
        // Replay and handler sources kept rare, else rtab_sel is almost always high
        rtab_full_i         = one_in_four();
        rtab_req_valid_i    = one_in_four();
        cmo_busy_i          = one_in_four();
        uc_busy_i           = one_in_four();
        rtab_check_hit_i    = next_random_bit();
        // Biased toward an active pipeline
        cachedir_init_ready_i = draw_bits(3) != 32'd0;
        refill_busy_i         = draw_bits(3) == 32'd0;
    endtask

    task automatic predict_outputs;
        req_flags_t f;
        logic       active;
        logic       park;
        logic       st1_nop;
        logic       st2_nop;
        logic       st0_cacheable;
        f             = st1_req_i.flags;
        active        = cachedir_init_ready_i & ~refill_busy_i;
        exp_action    = '0;
        exp_cause     = '0;
        exp_st2_alloc = 1'b0;
        park          = 1'b0;
        st1_nop       = 1'b0;
        st2_nop       = 1'b0;
        exp_rtab_sel  = rtab_full_i | rtab_req_valid_i | cmo_busy_i | uc_busy_i |
                        (st1_req_i.valid & is_fence(f));
        // Stage 2 miss takes an MSHR entry and costs one core slot
        if (active && st2_req_valid_i) begin
            exp_st2_alloc = 1'b1;
            st2_nop       = 1'b1;
        end
        if (active && st1_req_i.valid) begin
            if (f.is_cmo_fence || f.is_cmo_inval) begin
                exp_action.cmo_req_valid = 1'b1;
                st1_nop                  = 1'b1;
            end else if (f.uncacheable || f.is_amo) begin
                exp_action.uc_req_valid = 1'b1;
                st1_nop                 = 1'b1;
            end else if (f.is_load && !status_i.cachedir_hit) begin
                exp_action.wbuf_read_close_hit = 1'b1;
                st1_nop                        = 1'b1;
                // First failing condition names the cause
                if (status_i.mshr_hit) exp_cause.mshr_hit = 1'b1;
                else if (status_i.mshr_full) exp_cause.mshr_full = 1'b1;
                else if (status_i.wbuf_read_hit) exp_cause.wbuf_hit = 1'b1;
                else if (!status_i.mshr_alloc_ready) exp_cause.mshr_ready = 1'b1;
                park = exp_cause != '0;
                if (!park) begin
                    exp_action.rtab_commit = st1_req_i.rtab;
                    exp_action.st2_valid   = 1'b1;
                    exp_action.st2_we      = 1'b1;
                end
            end else if (f.is_load) begin
                exp_action.rtab_commit       = st1_req_i.rtab;
                exp_action.cachedir_updt_lru = 1'b1;
                exp_action.rsp_valid         = f.need_rsp;
                st1_nop                      = st1_req_i.rtab & ~exp_rtab_sel;
            end else if (f.is_store) begin
                exp_action.wbuf_write_valid = ~status_i.mshr_hit;
                exp_action.cachedata_write  = 1'b1;
                // Cacheable load in stage 0 would collide on the data RAM
                st1_nop = (arb_st0_req_valid_i & st0_req_i.is_load & ~st0_req_i.uncacheable) |
                          (st1_req_i.rtab & ~exp_rtab_sel);
                if (!status_i.cachedir_hit && status_i.mshr_hit) exp_cause.mshr_hit = 1'b1;
                else if (!status_i.wbuf_write_ready) exp_cause.wbuf_not_ready = 1'b1;
                park = exp_cause != '0;
                if (park) begin
                    st1_nop = 1'b1;
                end else begin
                    exp_action.rtab_commit            = st1_req_i.rtab;
                    exp_action.rsp_valid              = f.need_rsp;
                    exp_action.cachedir_updt_lru      = status_i.cachedir_hit;
                    exp_action.cachedata_write_enable = status_i.cachedir_hit;
                end
            end
        end
        exp_action.rtab_alloc = park & ~st1_req_i.rtab;
        exp_action.rtab_rback = park & st1_req_i.rtab;
        // Held pipeline passes both stage valid bits through
        exp_st2_valid      = active ? exp_action.st2_valid : st2_req_valid_i;
        exp_core_ready     = active & arb_st0_req_valid_i & ~(st1_nop | st2_nop);
        exp_refill_ready   = active & arb_refill_valid_i & ~st1_req_i.valid & ~st2_req_valid_i;
        exp_rtab_check     = exp_core_ready & ~exp_rtab_sel & ~is_fence(st0_req_i);
        exp_st0_rtab_alloc = exp_rtab_check & rtab_check_hit_i;
        exp_st1_valid      = active ? exp_core_ready & (exp_rtab_sel | is_fence(st0_req_i) |
                                                        ~rtab_check_hit_i) : st1_req_i.valid;
        st0_cacheable  = active & arb_st0_req_valid_i & ~st0_req_i.uncacheable;
        exp_mshr_check = st0_cacheable & (st0_req_i.is_load | st0_req_i.is_store |
                                          st0_req_i.is_amo);
        exp_dir_read   = st0_cacheable & ~st0_req_i.is_amo &
                         (st0_req_i.is_load | st0_req_i.is_store);
        exp_data_read  = st0_cacheable & st0_req_i.is_load &
                         ~(st1_req_i.valid & f.is_store & ~f.uncacheable);
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s cycle %0d expected %b actual %b",
                     name, cycle_count, expected, actual);
            stop_on_failure({"mismatch on ", name});
        end
    endtask

    task automatic compare_action(input string name, input st1_action_t expected,
                                  input st1_action_t actual);
        if (actual !== expected) begin
            $display("ERROR %s cycle %0d expected %b actual %b",
                     name, cycle_count, expected, actual);
            stop_on_failure({"mismatch on ", name});
        end
    endtask

    task automatic compare_cause(input string name, input rtab_cause_t expected,
                                 input rtab_cause_t actual);
        if (actual !== expected) begin
            $display("ERROR %s cycle %0d expected %b actual %b",
                     name, cycle_count, expected, actual);
            stop_on_failure({"mismatch on ", name});
        end
    endtask

    task automatic check_outputs;
        predict_outputs();
        compare_bit("rtab_sel", exp_rtab_sel, rtab_sel_o);
        compare_bit("core_ready", exp_core_ready, arb_st0_req_ready_o);
        compare_bit("refill_ready", exp_refill_ready, arb_refill_ready_o);
        compare_bit("rtab_check", exp_rtab_check, rtab_check_o);
        compare_bit("st0_rtab_alloc", exp_st0_rtab_alloc, st0_rtab_alloc_o);
        compare_bit("st1_valid", exp_st1_valid, st1_req_valid_o);
        compare_bit("st2_valid", exp_st2_valid, st2_req_valid_o);
        compare_bit("st2_mshr_alloc", exp_st2_alloc, st2_mshr_alloc_o);
        compare_bit("mshr_check", exp_mshr_check, st0_req_mshr_check_o);
        compare_bit("cachedir_read", exp_dir_read, st0_req_cachedir_read_o);
        compare_bit("cachedata_read", exp_data_read, st0_req_cachedata_read_o);
        compare_action("st1_action", exp_action, st1_action_o);
        compare_cause("st1_cause", exp_cause, st1_cause_o);
    endtask

    initial begin
        // Flag structs must keep the widths given in the settings header
        if ($bits(req_flags_t) != $bits(req_kind_vec_t) ||
            $bits(rtab_cause_t) != $bits(hpdcache_ctrl_status_pkg::rtab_cause_vec_t)) begin
            stop_on_failure("a flag struct width differs from its vector type");
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_random_inputs();
            @(posedge clk_i);
            check_outputs();
            @(negedge clk_i);
            // Assertion action blocks of the last rising edge have run by now
            if (DUT.u_properties.violation_count != 0) begin
                stop_on_failure("a bound assertion on the DUT outputs failed");
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
